// ==== dcache_top.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/cache_pkg.sv
verilog/dcache_cfg_regs.sv
verilog/dcache_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/dcache_tb.sv

// ==== Makefile ====
# Verilator build, run and lint of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/dcache_tb.sv ====
// Data cache subsystem testbench
// Drives a table of configuration, CPU and memory operations into the
// cache top level and answers its bus cycles from a shadow memory
// with random wait states and retries

`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

	localparam int ROW_CYCLES = 400;
	// Bus addresses from here up never get an answer
	localparam logic [15:0] NO_ANSWER_ADR = 16'h8000;
	localparam cache_pkg::attr_e CA = cache_pkg::CACHEABLE;
	localparam cache_pkg::attr_e NC = cache_pkg::NON_CACHEABLE;

	typedef enum logic [2:0] {
		OP_CFG_WR, OP_CFG_RD, OP_RD, OP_WR, OP_POKE, OP_MEM_CHK
	} op_e;

	typedef struct packed {
		op_e op;
		logic [15:0] adr;
		logic [31:0] dat;
		logic [3:0] sel;
		cache_pkg::attr_e attr;
		logic [31:0] exp;
		logic exp_err;
	} row_t;

	logic clk_i;
	logic rst_i;
	logic req_i;
	logic we_i;
	bus_pkg::adr_t adr_i;
	bus_pkg::beat_t wdat_i;
	bus_pkg::sel_t sel_i;
	cache_pkg::attr_e attr_i;
	logic ack_o;
	logic err_o;
	bus_pkg::beat_t rdat_o;
	logic bus_cyc_o;
	logic bus_we_o;
	bus_pkg::adr_t bus_adr_o;
	bus_pkg::beat_t bus_dat_o;
	bus_pkg::sel_t bus_sel_o;
	logic bus_ack_i;
	logic bus_rty_i;
	bus_pkg::beat_t bus_dat_i;
	logic cfg_we_i;
	cache_pkg::reg_e cfg_adr_i;
	bus_pkg::beat_t cfg_dat_i;
	bus_pkg::beat_t cfg_dat_o;

	logic [31:0] shadow [256];
	row_t rows[$];
	int wait_left;
	int cycles = 0;
	int cycle_limit = 0;

	dcache_top dut0 (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// Watchdog, armed once the table length is known
	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the test table did not complete", cycles);
			$display("Result: FAILED");
			$fatal(1, "Simulation timeout");
		end
	end

	// ============================================================
	// Reference rules
	// ============================================================

	// Power-up content of each shadow word, built from its word address
	function automatic logic [31:0] init_word(input logic [15:0] adr);
		logic [7:0] w;
		w = adr[9:2];
		return {w ^ 8'h5a, 8'hc3, ~w, w};
	endfunction

	// Byte lanes with sel set take the new data
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got %h, expected %h", name, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	// ============================================================
	// Memory model and CPU driver
	// ============================================================

	// One step of the memory model, run 1 ns after each rising edge
	// An open cycle gets ack after 1 to 3 cycles, or a retry one time in five
	task automatic answer_bus();
		logic [7:0] idx;
		idx = bus_adr_o[9:2];
		bus_ack_i = 1'b0;
		bus_rty_i = 1'b0;
		bus_dat_i = '0;
		if (!bus_cyc_o) begin
			wait_left = -1;
		end else if (bus_adr_o < NO_ANSWER_ADR) begin
			if (wait_left < 0)
				wait_left = $urandom_range(2, 0);
			if (wait_left > 0) begin
				wait_left--;
			end else if ($urandom_range(4, 0) == 0) begin
				bus_rty_i = 1'b1;
			end else begin
				bus_ack_i = 1'b1;
				if (bus_we_o)
					shadow[idx] = merge_bytes(shadow[idx], bus_dat_o, bus_sel_o);
				else
					bus_dat_i = shadow[idx];
			end
		end
	endtask

	task automatic tick();
		@(posedge clk_i);
		#1;
		answer_bus();
	endtask

	// The request stays up until the ack pulse, the watchdog covers a lost ack
	task automatic run_access(input row_t r);
		req_i = 1'b1;
		we_i = (r.op == OP_WR);
		adr_i = r.adr;
		wdat_i = r.dat;
		sel_i = r.sel;
		attr_i = r.attr;
		tick();
		while (!ack_o)
			tick();
		check_value("err_o", {31'd0, err_o}, {31'd0, r.exp_err});
		if (r.op == OP_RD && !r.exp_err)
			check_value("rdat_o", rdat_o, r.exp);
		req_i = 1'b0;
		we_i = 1'b0;
	endtask

	task automatic apply_row(input row_t r);
		case (r.op)
			OP_CFG_WR: begin
				cfg_we_i = 1'b1;
				cfg_adr_i = cache_pkg::reg_e'(r.adr[1:0]);
				cfg_dat_i = r.dat;
				tick();
				cfg_we_i = 1'b0;
				// Gives a flush pulse time to clear the valid bits
				tick();
			end
			OP_CFG_RD: begin
				cfg_adr_i = cache_pkg::reg_e'(r.adr[1:0]);
				tick();
				check_value("cfg_dat_o", cfg_dat_o, r.exp);
			end
			OP_POKE: shadow[r.adr[9:2]] = r.dat;
			OP_MEM_CHK: check_value("shadow memory", shadow[r.adr[9:2]], r.exp);
			default: run_access(r);
		endcase
	endtask

	task automatic add_row(input op_e op, input logic [15:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, input cache_pkg::attr_e attr, input logic [31:0] exp,
		input logic exp_err);
		rows.push_back(row_t'{op, adr, dat, sel, attr, exp, exp_err});
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================

	task automatic build_table();
		logic [31:0] merged;
		merged = merge_bytes(init_word(16'h0044), 32'h1122_3344, 4'b0110);
		// Miss then hit on a line whose memory changed behind the cache
		add_row(OP_CFG_WR, cache_pkg::REG_CTRL, 32'h1, 4'h0, NC, 32'h0, 1'b0);
		add_row(OP_CFG_RD, cache_pkg::REG_CTRL, 32'h0, 4'h0, NC, 32'h1, 1'b0);
		add_row(OP_RD, 16'h0048, 32'h0, 4'hf, CA, init_word(16'h0048), 1'b0);
		add_row(OP_POKE, 16'h0048, 32'hdead_beef, 4'h0, NC, 32'h0, 1'b0);
		add_row(OP_RD, 16'h0048, 32'h0, 4'hf, CA, init_word(16'h0048), 1'b0);
		add_row(OP_CFG_RD, cache_pkg::REG_HITS, 32'h0, 4'h0, NC, 32'h1, 1'b0);
		add_row(OP_CFG_RD, cache_pkg::REG_MISSES, 32'h0, 4'h0, NC, 32'h1, 1'b0);
		// Partial write hit lands in both memory and cache
		add_row(OP_WR, 16'h0044, 32'h1122_3344, 4'b0110, CA, 32'h0, 1'b0);
		add_row(OP_MEM_CHK, 16'h0044, 32'h0, 4'h0, NC, merged, 1'b0);
		add_row(OP_RD, 16'h0044, 32'h0, 4'hf, CA, merged, 1'b0);
		// Bypass by attribute and with the cache switched off
		// Word 0x40 sits in a valid line, so only a true bypass sees the poke
		add_row(OP_POKE, 16'h0040, 32'h0bad_f00d, 4'h0, NC, 32'h0, 1'b0);
		add_row(OP_RD, 16'h0040, 32'h0, 4'hf, NC, 32'h0bad_f00d, 1'b0);
		add_row(OP_CFG_WR, cache_pkg::REG_CTRL, 32'h0, 4'h0, NC, 32'h0, 1'b0);
		add_row(OP_RD, 16'h0048, 32'h0, 4'hf, CA, 32'hdead_beef, 1'b0);
		add_row(OP_CFG_RD, cache_pkg::REG_HITS, 32'h0, 4'h0, NC, 32'h2, 1'b0);
		add_row(OP_CFG_RD, cache_pkg::REG_MISSES, 32'h0, 4'h0, NC, 32'h1, 1'b0);
		// Enable with flush, the stale line must be fetched again
		add_row(OP_CFG_WR, cache_pkg::REG_CTRL, 32'h3, 4'h0, NC, 32'h0, 1'b0);
		add_row(OP_CFG_RD, cache_pkg::REG_CTRL, 32'h0, 4'h0, NC, 32'h1, 1'b0);
		add_row(OP_RD, 16'h0048, 32'h0, 4'hf, CA, 32'hdead_beef, 1'b0);
		add_row(OP_CFG_RD, cache_pkg::REG_MISSES, 32'h0, 4'h0, NC, 32'h2, 1'b0);
		// Mixed traffic, several lines share set 4 to exercise the victim pick
		add_row(OP_WR, 16'h0100, 32'hcafe_0001, 4'hf, NC, 32'h0, 1'b0);
		add_row(OP_MEM_CHK, 16'h0100, 32'h0, 4'h0, NC, 32'hcafe_0001, 1'b0);
		add_row(OP_RD, 16'h0100, 32'h0, 4'hf, CA, 32'hcafe_0001, 1'b0);
		add_row(OP_RD, 16'h0104, 32'h0, 4'hf, CA, init_word(16'h0104), 1'b0);
		add_row(OP_RD, 16'h01c8, 32'h0, 4'hf, CA, init_word(16'h01c8), 1'b0);
		add_row(OP_RD, 16'h00c8, 32'h0, 4'hf, CA, init_word(16'h00c8), 1'b0);
		add_row(OP_RD, 16'h004c, 32'h0, 4'hf, CA, init_word(16'h004c), 1'b0);
		add_row(OP_WR, 16'h0108, 32'h5555_aaaa, 4'hf, CA, 32'h0, 1'b0);
		add_row(OP_RD, 16'h0108, 32'h0, 4'hf, CA, 32'h5555_aaaa, 1'b0);
		// Silent region times out, normal traffic resumes afterwards
		add_row(OP_RD, 16'h8000, 32'h0, 4'hf, NC, 32'h0, 1'b1);
		add_row(OP_RD, 16'h0030, 32'h0, 4'hf, CA, init_word(16'h0030), 1'b0);
	endtask

	initial begin
		void'($urandom(89));
		rst_i = 1'b1;
		req_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		wdat_i = '0;
		sel_i = '0;
		attr_i = NC;
		cfg_we_i = 1'b0;
		cfg_adr_i = cache_pkg::REG_CTRL;
		cfg_dat_i = '0;
		bus_ack_i = 1'b0;
		bus_rty_i = 1'b0;
		bus_dat_i = '0;
		wait_left = -1;
		for (int i = 0; i < 256; i++)
			shadow[i] = init_word(16'(i * 4));
		build_table();
		cycle_limit = rows.size() * ROW_CYCLES;
		repeat (2) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		foreach (rows[i])
			apply_row(rows[i]);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
// Data cache subsystem top level
// Joins the configuration registers, the tag and data store and
// the access controller between the CPU port and the memory bus

`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
	input wire clk_i,
	input wire rst_i,
	// CPU request port
	input wire req_i,
	input wire we_i,
	input wire bus_pkg::adr_t adr_i,
	input wire bus_pkg::beat_t wdat_i,
	input wire bus_pkg::sel_t sel_i,
	input wire cache_pkg::attr_e attr_i,
	output logic ack_o,
	output logic err_o,
	output bus_pkg::beat_t rdat_o,
	// Memory bus
	output logic bus_cyc_o,
	output logic bus_we_o,
	output bus_pkg::adr_t bus_adr_o,
	output bus_pkg::beat_t bus_dat_o,
	output bus_pkg::sel_t bus_sel_o,
	input wire bus_ack_i,
	input wire bus_rty_i,
	input wire bus_pkg::beat_t bus_dat_i,
	// Configuration port
	input wire cfg_we_i,
	input wire cache_pkg::reg_e cfg_adr_i,
	input wire bus_pkg::beat_t cfg_dat_i,
	output bus_pkg::beat_t cfg_dat_o
);

	logic enable;
	logic flush;
	logic hit;
	bus_pkg::beat_t hit_data;
	logic fill_we;
	cache_pkg::way_t fill_way;
	cache_pkg::beat_idx_t fill_beat;
	bus_pkg::beat_t fill_data;
	logic fill_done;
	logic wr_hit_we;
	logic hit_evt;
	logic miss_evt;

	dcache_cfg_regs u_regs (
		.clk_i(clk_i), .rst_i(rst_i),
		.cfg_we_i(cfg_we_i), .cfg_adr_i(cfg_adr_i),
		.cfg_dat_i(cfg_dat_i), .cfg_dat_o(cfg_dat_o),
		.hit_evt_i(hit_evt), .miss_evt_i(miss_evt),
		.enable_o(enable), .flush_o(flush)
	);

	// The hit way is used inside the store only
	dcache_store u_store (
		.clk_i(clk_i), .rst_i(rst_i), .flush_i(flush),
		.adr_i(adr_i),
		.hit_o(hit), .hit_way_o(), .hit_data_o(hit_data),
		.fill_we_i(fill_we), .fill_way_i(fill_way),
		.fill_beat_i(fill_beat), .fill_data_i(fill_data),
		.fill_done_i(fill_done),
		.wr_hit_we_i(wr_hit_we), .wdat_i(wdat_i), .sel_i(sel_i)
	);

	dcache_ctrl u_ctrl (
		.clk_i(clk_i), .rst_i(rst_i), .enable_i(enable),
		.req_i(req_i), .we_i(we_i), .adr_i(adr_i),
		.wdat_i(wdat_i), .sel_i(sel_i), .attr_i(attr_i),
		.ack_o(ack_o), .err_o(err_o), .rdat_o(rdat_o),
		.hit_i(hit), .hit_data_i(hit_data),
		.fill_we_o(fill_we), .fill_way_o(fill_way),
		.fill_beat_o(fill_beat), .fill_data_o(fill_data),
		.fill_done_o(fill_done), .wr_hit_we_o(wr_hit_we),
		.hit_evt_o(hit_evt), .miss_evt_o(miss_evt),
		.bus_cyc_o(bus_cyc_o), .bus_we_o(bus_we_o), .bus_adr_o(bus_adr_o),
		.bus_dat_o(bus_dat_o), .bus_sel_o(bus_sel_o),
		.bus_ack_i(bus_ack_i), .bus_rty_i(bus_rty_i), .bus_dat_i(bus_dat_i)
	);

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
// Data cache controller
// Serves read hits from the store, fetches lines on cacheable read
// misses, passes writes and bypass accesses to the memory bus, and
// handles retry back-off and the bus timeout

`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl (
	input wire clk_i,
	input wire rst_i,
	input wire enable_i,
	input wire req_i,
	input wire we_i,
	input wire bus_pkg::adr_t adr_i,
	input wire bus_pkg::beat_t wdat_i,
	input wire bus_pkg::sel_t sel_i,
	input wire cache_pkg::attr_e attr_i,
	output logic ack_o,
	output logic err_o,
	output bus_pkg::beat_t rdat_o,
	input wire hit_i,
	input wire bus_pkg::beat_t hit_data_i,
	output logic fill_we_o,
	output cache_pkg::way_t fill_way_o,
	output cache_pkg::beat_idx_t fill_beat_o,
	output bus_pkg::beat_t fill_data_o,
	output logic fill_done_o,
	output logic wr_hit_we_o,
	output logic hit_evt_o,
	output logic miss_evt_o,
	output logic bus_cyc_o,
	output logic bus_we_o,
	output bus_pkg::adr_t bus_adr_o,
	output bus_pkg::beat_t bus_dat_o,
	output bus_pkg::sel_t bus_sel_o,
	input wire bus_ack_i,
	input wire bus_rty_i,
	input wire bus_pkg::beat_t bus_dat_i
);

	localparam int TO_W = $clog2(`BUS_TIMEOUT + 1);
	localparam logic [TO_W-1:0] TO_LAST = TO_W'(`BUS_TIMEOUT - 1);
	localparam cache_pkg::beat_idx_t LAST_BEAT = cache_pkg::beat_idx_t'(`LINE_BEATS - 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_BUS,
		ST_GAP,
		ST_BACKOFF,
		ST_DONE
	} state_e;

	state_e state_q;
	logic [15:0] lfsr_q;
	logic [TO_W-1:0] to_cnt_q;
	logic [2:0] backoff_q;
	cache_pkg::beat_idx_t beat_q;
	cache_pkg::way_t victim_q;
	logic fill_q;
	logic cacheable;
	logic beat_ack;

	// Only cacheable requests with the cache on ever look at the store
	assign cacheable = enable_i && (attr_i == cache_pkg::CACHEABLE);
	assign beat_ack = (state_q == ST_BUS) && bus_ack_i;

	// Store writes happen in the ack cycle itself
	assign fill_we_o = beat_ack && fill_q;
	assign fill_way_o = victim_q;
	assign fill_beat_o = beat_q;
	assign fill_data_o = bus_dat_i;
	assign fill_done_o = fill_we_o && (beat_q == LAST_BEAT);
	assign wr_hit_we_o = beat_ack && bus_we_o && hit_i;

	// Free-running 16-bit Fibonacci LFSR, taps 16 14 13 11
	always_ff @(posedge clk_i) begin
		if (rst_i)
			lfsr_q <= 16'hace1;
		else
			lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
	end

	// ============================================================
	// Access state machine
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
			{ack_o, err_o, hit_evt_o, miss_evt_o} <= '0;
			{bus_cyc_o, bus_we_o, fill_q} <= '0;
			bus_adr_o <= '0;
			bus_dat_o <= '0;
			bus_sel_o <= '0;
			rdat_o <= '0;
			beat_q <= '0;
			victim_q <= '0;
			to_cnt_q <= '0;
			backoff_q <= '0;
		end else begin
			// Acknowledge and event outputs are single-cycle pulses
			{ack_o, err_o, hit_evt_o, miss_evt_o} <= '0;
			case (state_q)
				ST_IDLE: begin
					if (req_i) begin
						to_cnt_q <= '0;
						beat_q <= '0;
						if (!we_i && cacheable && hit_i) begin
							rdat_o <= hit_data_i;
							ack_o <= 1'b1;
							hit_evt_o <= 1'b1;
							state_q <= ST_DONE;
						end else if (!we_i && cacheable) begin
							// Line fill starts at word 0 of the line
							miss_evt_o <= 1'b1;
							fill_q <= 1'b1;
							victim_q <= lfsr_q[0];
							bus_cyc_o <= 1'b1;
							bus_we_o <= 1'b0;
							bus_adr_o <= {adr_i[`ADDR_W-1:cache_pkg::OFFSET_W],
								{cache_pkg::OFFSET_W{1'b0}}};
							bus_sel_o <= '1;
							state_q <= ST_BUS;
						end else begin
							// Single beat for writes and bypass reads
							fill_q <= 1'b0;
							bus_cyc_o <= 1'b1;
							bus_we_o <= we_i;
							bus_adr_o <= {adr_i[`ADDR_W-1:cache_pkg::BYTE_OFF_W],
								{cache_pkg::BYTE_OFF_W{1'b0}}};
							bus_dat_o <= wdat_i;
							bus_sel_o <= we_i ? sel_i : '1;
							state_q <= ST_BUS;
						end
					end
				end
				ST_BUS: begin
					to_cnt_q <= to_cnt_q + 1'b1;
					if (bus_ack_i) begin
						bus_cyc_o <= 1'b0;
						// Keep the requested word of a fill, or the bypass read data
						if (!bus_we_o && (!fill_q ||
							beat_q == adr_i[cache_pkg::BYTE_OFF_W +: cache_pkg::BEAT_IDX_W]))
							rdat_o <= bus_dat_i;
						if (fill_q && (beat_q != LAST_BEAT)) begin
							beat_q <= beat_q + 1'b1;
							bus_adr_o[cache_pkg::BYTE_OFF_W +: cache_pkg::BEAT_IDX_W] <=
								beat_q + 1'b1;
							state_q <= ST_GAP;
						end else begin
							ack_o <= 1'b1;
							state_q <= ST_DONE;
						end
					end else if (bus_rty_i) begin
						// Back off for 1 to 8 cycles before the same beat again
						bus_cyc_o <= 1'b0;
						backoff_q <= lfsr_q[3:1];
						state_q <= ST_BACKOFF;
					end else if (to_cnt_q == TO_LAST) begin
						bus_cyc_o <= 1'b0;
						ack_o <= 1'b1;
						err_o <= 1'b1;
						state_q <= ST_DONE;
					end
				end
				// Bus idle for one cycle between fill beats
				ST_GAP: begin
					bus_cyc_o <= 1'b1;
					to_cnt_q <= '0;
					state_q <= ST_BUS;
				end
				ST_BACKOFF: begin
					if (backoff_q == '0) begin
						bus_cyc_o <= 1'b1;
						to_cnt_q <= '0;
						state_q <= ST_BUS;
					end else begin
						backoff_q <= backoff_q - 1'b1;
					end
				end
				// Ack cycle, the CPU drops its request after this
				ST_DONE: state_q <= ST_IDLE;
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dcache_store.sv ====
// Data cache storage
// Tag, valid and data arrays for every way and set, with the
// combinational hit lookup, the line fill path and the byte
// merge of a write-through hit

`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_store (
	input wire clk_i,
	input wire rst_i,
	input wire flush_i,
	input wire bus_pkg::adr_t adr_i,
	output logic hit_o,
	output cache_pkg::way_t hit_way_o,
	output bus_pkg::beat_t hit_data_o,
	input wire fill_we_i,
	input wire cache_pkg::way_t fill_way_i,
	input wire cache_pkg::beat_idx_t fill_beat_i,
	input wire bus_pkg::beat_t fill_data_i,
	input wire fill_done_i,
	input wire wr_hit_we_i,
	input wire bus_pkg::beat_t wdat_i,
	input wire bus_pkg::sel_t sel_i
);

	// ============================================================
	// Arrays and address split
	// ============================================================

	// Data words are addressed by set and word within the line
	bus_pkg::beat_t data_mem [`WAYS][`SETS*`LINE_BEATS];
	cache_pkg::tag_t tag_mem [`WAYS][`SETS];
	logic [`SETS-1:0] valid_q [`WAYS];

	cache_pkg::index_t idx;
	cache_pkg::beat_idx_t beat;
	cache_pkg::tag_t tag;

	assign beat = adr_i[cache_pkg::BYTE_OFF_W +: cache_pkg::BEAT_IDX_W];
	assign idx = adr_i[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
	assign tag = adr_i[`ADDR_W-1:cache_pkg::OFFSET_W+cache_pkg::INDEX_W];

	// ============================================================
	// Lookup
	// ============================================================

	// A line is only ever present in one way, so the last match wins harmlessly
	always_comb begin
		hit_o = 1'b0;
		hit_way_o = '0;
		for (int w = 0; w < `WAYS; w++) begin
			if (valid_q[w][idx] && (tag_mem[w][idx] == tag)) begin
				hit_o = 1'b1;
				hit_way_o = cache_pkg::way_t'(w);
			end
		end
	end

	assign hit_data_o = data_mem[hit_way_o][{idx, beat}];

	// ============================================================
	// Updates
	// ============================================================

	// Fill beats land in the victim way, the tag follows the CPU address
	// Write hits merge only the enabled byte lanes
	always_ff @(posedge clk_i) begin
		if (fill_we_i) begin
			data_mem[fill_way_i][{idx, fill_beat_i}] <= fill_data_i;
			tag_mem[fill_way_i][idx] <= tag;
		end
		if (wr_hit_we_i) begin
			for (int b = 0; b < `BEAT_W/8; b++) begin
				if (sel_i[b])
					data_mem[hit_way_o][{idx, beat}][b*8 +: 8] <= wdat_i[b*8 +: 8];
			end
		end
	end

	// The victim line goes invalid on its first fill beat and comes back
	// only when the whole line is in, so an aborted fill leaves it invalid
	always_ff @(posedge clk_i) begin
		if (rst_i || flush_i) begin
			for (int w = 0; w < `WAYS; w++)
				valid_q[w] <= '0;
		end else if (fill_done_i) begin
			valid_q[fill_way_i][idx] <= 1'b1;
		end else if (fill_we_i) begin
			valid_q[fill_way_i][idx] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dcache_cfg_regs.sv ====
// Data cache configuration and statistics registers
// Holds the enable bit, issues the flush pulse and counts
// cacheable read hits and misses for the controller

`timescale 1ns/100ps
`default_nettype none

`include "dcache_config.svh"

module dcache_cfg_regs (
	input wire clk_i,
	input wire rst_i,
	input wire cfg_we_i,
	input wire cache_pkg::reg_e cfg_adr_i,
	input wire bus_pkg::beat_t cfg_dat_i,
	output bus_pkg::beat_t cfg_dat_o,
	input wire hit_evt_i,
	input wire miss_evt_i,
	output logic enable_o,
	output logic flush_o
);

	logic ctrl_we;
	bus_pkg::beat_t hits_q;
	bus_pkg::beat_t misses_q;

	assign ctrl_we = cfg_we_i && (cfg_adr_i == cache_pkg::REG_CTRL);

	// Enable is stored, flush only lives for the cycle after the write
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			enable_o <= 1'b0;
			flush_o <= 1'b0;
			hits_q <= '0;
			misses_q <= '0;
		end else begin
			flush_o <= ctrl_we && cfg_dat_i[1];
			if (ctrl_we)
				enable_o <= cfg_dat_i[0];
			// Counters wrap silently
			if (hit_evt_i)
				hits_q <= hits_q + 1'b1;
			if (miss_evt_i)
				misses_q <= misses_q + 1'b1;
		end
	end

	// Read mux, the flush bit always reads back as zero
	always_comb begin
		case (cfg_adr_i)
			cache_pkg::REG_CTRL: cfg_dat_o = {{(`BEAT_W-1){1'b0}}, enable_o};
			cache_pkg::REG_HITS: cfg_dat_o = hits_q;
			cache_pkg::REG_MISSES: cfg_dat_o = misses_q;
			default: cfg_dat_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
// Cache types
// Request attribute, register map and the address split into
// tag, set index and word within the line

`default_nettype none

`include "dcache_config.svh"

package cache_pkg;

	// Address split, byte offset in a word, word in a line, set index
	localparam int BYTE_OFF_W = $clog2(`BEAT_W/8);
	localparam int BEAT_IDX_W = $clog2(`LINE_BEATS);
	localparam int OFFSET_W = BYTE_OFF_W + BEAT_IDX_W;
	localparam int INDEX_W = $clog2(`SETS);

	// Cacheability of a CPU request
	typedef enum logic {
		NON_CACHEABLE = 1'b0,
		CACHEABLE = 1'b1
	} attr_e;

	// Configuration register addresses
	typedef enum logic [1:0] {
		REG_CTRL = 2'd0,
		REG_HITS = 2'd1,
		REG_MISSES = 2'd2
	} reg_e;

	typedef logic [$clog2(`WAYS)-1:0] way_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [BEAT_IDX_W-1:0] beat_idx_t;
	typedef logic [`ADDR_W-OFFSET_W-INDEX_W-1:0] tag_t;

endpackage

`default_nettype wire

// ==== verilog/bus_pkg.sv ====
// Memory bus types
// Data beat, byte select and byte address of the classic
// single-master bus on the memory side of the data cache

`default_nettype none

`include "dcache_config.svh"

package bus_pkg;

	// ============================================================
	// Bus payload types
	// ============================================================

	// One data word, also the CPU data width
	typedef logic [`BEAT_W-1:0] beat_t;

	// One enable per byte lane of a beat
	typedef logic [`BEAT_W/8-1:0] sel_t;

	// Byte address, word aligned on the bus
	typedef logic [`ADDR_W-1:0] adr_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_config.svh ====
// Data cache build configuration
// Sizes of the address, data beat, line, set and way arrays
// and the bus timeout used by the controller

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Byte address width on both the CPU and the memory bus
`define ADDR_W 16

// Width of one data word on the CPU port and one memory bus beat
`define BEAT_W 32

// Beats per cache line, four words give a 16-byte line
`define LINE_BEATS 4

// Sets and ways of the cache array
`define SETS 8
`define WAYS 2

// Cycles the bus cycle may stay open without ack or retry
`define BUS_TIMEOUT 255

`endif
